// ==== source/tracking_pkg.sv ====
package tracking_pkg;

	// bus widths
	localparam int mem_addr_w = 18;
	localparam int word_w = 32;
	localparam int buf_addr_w = 6;
	localparam int byte_w = 8;
	localparam int ptr_idx_w = 5;
	localparam int color_w = 3;
	localparam int rank_w = 2;
	localparam int kind_w = 3;
	localparam int state_w = 3;

	// pointer table walk
	localparam int ptr_slots = 20;
	localparam int rank_slots = 6;       // pointer slots per rank
	localparam int max_rank = 2;
	localparam int blob_region_base = 200000;

	// colour codes as stored in word one, minus 1
	localparam int color_red = 0;
	localparam int color_orange = 1;
	localparam int color_yellow = 2;
	localparam int color_green = 3;
	localparam int color_blue = 4;
	localparam int color_purple = 5;
	localparam int color_count = 6;

	localparam int marker_start = 176;
	localparam int marker_lf = 10;
	localparam int marker_cr = 13;

	localparam int mode1_bytes = 28;
	localparam int mode2_bytes = 52;

	// packet slot layout
	localparam int centroid_base = 2;    // x of rank 1 red
	localparam int mode1_size_base = 14;
	localparam int mode2_size_base = 26;
	localparam int mode1_rank_stride = 6;
	localparam int mode2_rank_stride = 12;

	// kind of buffer write
	localparam int kind_clear = 0;
	localparam int kind_start = 1;
	localparam int kind_protocol = 2;
	localparam int kind_lf = 3;
	localparam int kind_cr = 4;
	localparam int kind_field = 5;

	// sequencer states
	localparam int st_idle = 0;
	localparam int st_clear = 1;
	localparam int st_markers = 2;
	localparam int st_examine = 3;
	localparam int st_fetch = 4;
	localparam int st_store = 5;
	localparam int st_done = 6;

endpackage

// ==== source/packet_buffer.sv ====
module packet_buffer
	import tracking_pkg::*;
(
	input  logic clk,
	input  logic write_strobe,
	input  logic [buf_addr_w-1:0] buf_addr,
	input  logic [byte_w-1:0] buf_byte,
	input  logic [buf_addr_w-1:0] read_addr,
	output logic [byte_w-1:0] read_data
);
	logic [byte_w-1:0] mem [0:(1 << buf_addr_w) - 1];

	// port a, written by the assembler
	always_ff @(posedge clk) begin
		if (write_strobe)
			mem[buf_addr] <= buf_byte;
	end

	// port b, external packet reader
	always_ff @(posedge clk) begin
		read_data <= mem[read_addr];   // one cycle latency
	end

endmodule

// ==== source/slot_mapper.sv ====
module slot_mapper
	import tracking_pkg::*;
(
	input  logic [kind_w-1:0] write_kind,
	input  logic [1:0] field_index,
	input  logic [buf_addr_w-1:0] clear_addr,
	input  logic [rank_w-1:0] blob_rank,
	input  logic [color_w-1:0] blob_color,
	input  logic mode_two,
	input  logic [word_w-1:0] blob_word,
	output logic [buf_addr_w-1:0] buf_addr,
	output logic [byte_w-1:0] buf_byte
);
	logic [buf_addr_w-1:0] pkt_len;
	logic [buf_addr_w-1:0] rank_offset;
	logic [buf_addr_w-1:0] field_base;
	logic [buf_addr_w-1:0] color_offset;
	logic [color_w-1:0] color_index;
	logic [byte_w-1:0] field_byte;

	assign pkt_len = mode_two ? buf_addr_w'(mode2_bytes) : buf_addr_w'(mode1_bytes);
	assign rank_offset = (blob_rank != rank_w'(2)) ? '0 :
		mode_two ? buf_addr_w'(mode2_rank_stride) : buf_addr_w'(mode1_rank_stride);
	assign field_base = !field_index[1] ? buf_addr_w'(centroid_base) :
		mode_two ? buf_addr_w'(mode2_size_base) : buf_addr_w'(mode1_size_base);
	assign color_offset = buf_addr_w'({color_index, 1'b0});   // two bytes per colour

	// mode 1 packs red, green, blue into three adjacent pairs
	always_comb begin
		color_index = blob_color;
		if (!mode_two) begin
			case (blob_color)
				color_w'(color_green): color_index = color_w'(1);
				color_w'(color_blue): color_index = color_w'(2);
				default: color_index = '0;
			endcase
		end
	end

	always_comb begin
		case (field_index)
			2'd0: field_byte = blob_word[31:24];   // x centroid
			2'd1: field_byte = blob_word[23:16];   // y centroid
			2'd2: field_byte = blob_word[15:8];
			default: field_byte = blob_word[7:0];
		endcase
	end

	always_comb begin
		case (write_kind)
			kind_w'(kind_clear): begin
				buf_addr = clear_addr;
				buf_byte = '0;
			end
			kind_w'(kind_start): begin
				buf_addr = '0;
				buf_byte = byte_w'(marker_start);
			end
			kind_w'(kind_protocol): begin
				buf_addr = buf_addr_w'(1);
				buf_byte = mode_two ? byte_w'(2) : byte_w'(1);
			end
			kind_w'(kind_lf): begin
				buf_addr = pkt_len - buf_addr_w'(2);
				buf_byte = byte_w'(marker_lf);
			end
			kind_w'(kind_cr): begin
				buf_addr = pkt_len - buf_addr_w'(1);
				buf_byte = byte_w'(marker_cr);
			end
			default: begin   // blob field
				buf_addr = field_base + rank_offset + color_offset + buf_addr_w'(field_index[0]);
				buf_byte = field_byte;
			end
		endcase
	end

endmodule

// ==== source/blob_fetch.sv ====
module blob_fetch
	import tracking_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic fetch_start,
	input  logic [mem_addr_w-1:0] blob_pointer,
	input  logic [word_w-1:0] mem_data,
	input  logic mode_two,
	input  logic clear_display,
	output logic [mem_addr_w-1:0] mem_address,
	output logic fetch_done,
	output logic color_valid,
	output logic [color_w-1:0] blob_color,
	output logic [word_w-1:0] blob_word,
	output logic [color_count-1:0] tracking_display
);
	logic [2:0] fetch_pipe;              // one bit per cycle after fetch_start
	logic [byte_w-1:0] color_code;
	logic rgb_color;

	assign fetch_done = fetch_pipe[2];
	assign blob_color = color_code[color_w-1:0];
	assign rgb_color = (blob_color == color_w'(color_red)) ||
		(blob_color == color_w'(color_green)) ||
		(blob_color == color_w'(color_blue));
	assign color_valid = (color_code < byte_w'(color_count)) && (mode_two || rgb_color);

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_pipe <= '0;
			mem_address <= '0;
			tracking_display <= '0;
		end else begin
			fetch_pipe <= {fetch_pipe[1:0], fetch_start};
			if (fetch_start)
				mem_address <= blob_pointer;              // word one
			else if (fetch_pipe[0])
				mem_address <= mem_address + 1'b1;        // word two
			if (clear_display)
				tracking_display <= '0;
			else if (fetch_done && color_valid)
				tracking_display[blob_color] <= 1'b1;
		end
	end

	// memory answers one cycle after the address, so word one lands in pipe stage 1
	always_ff @(posedge clk) begin
		if (fetch_pipe[1])
			color_code <= mem_data[byte_w-1:0] - 1'b1;   // code 0 wraps to an invalid colour
		if (fetch_pipe[2])
			blob_word <= mem_data;   // x, y, size high, size low
	end

	assert property (@(posedge clk) disable iff (reset) fetch_start |-> ##3 fetch_done);

endmodule

// ==== source/tracking_sequencer.sv ====
module tracking_sequencer
	import tracking_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enable_tracking,
	input  logic [1:0] mode_switches,
	input  logic [ptr_idx_w-1:0] number_of_valid_blobs,
	input  logic [mem_addr_w-1:0] blob_pointer,
	input  logic fetch_done,
	input  logic color_valid,
	input  logic [color_w-1:0] blob_color,
	output logic [ptr_idx_w-1:0] pointer_index,
	output logic fetch_start,
	output logic write_strobe,
	output logic [kind_w-1:0] write_kind,
	output logic [1:0] field_index,
	output logic [buf_addr_w-1:0] clear_addr,
	output logic [rank_w-1:0] blob_rank,
	output logic mode_two,
	output logic [6:0] bytes_to_transmit,
	output logic tracking_done
);
	logic [state_w-1:0] state;
	logic [1:0] step;                    // marker or field counter
	logic [ptr_idx_w-1:0] blobs_written;
	logic pointer_valid;
	logic run_over;

	// rank follows the pointer slot in groups of six
	assign blob_rank = (pointer_index < ptr_idx_w'(rank_slots)) ? rank_w'(1) :
		(pointer_index < ptr_idx_w'(2 * rank_slots)) ? rank_w'(2) : rank_w'(3);

	assign pointer_valid = blob_pointer >= mem_addr_w'(blob_region_base);
	assign run_over = (pointer_index >= ptr_idx_w'(ptr_slots)) ||
		(blob_rank > rank_w'(max_rank)) ||
		(blobs_written == number_of_valid_blobs);

	assign write_strobe = (state == state_w'(st_clear)) || (state == state_w'(st_markers)) ||
		(state == state_w'(st_store));
	assign field_index = step;
	assign bytes_to_transmit = mode_two ? 7'(mode2_bytes) : 7'(mode1_bytes);
	assign tracking_done = state == state_w'(st_done);

	always_comb begin
		write_kind = kind_w'(kind_clear);
		if (state == state_w'(st_markers)) begin
			case (step)
				2'd0: write_kind = kind_w'(kind_start);
				2'd1: write_kind = kind_w'(kind_protocol);
				2'd2: write_kind = kind_w'(kind_lf);
				default: write_kind = kind_w'(kind_cr);
			endcase
		end else if (state == state_w'(st_store)) begin
			write_kind = kind_w'(kind_field);
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !enable_tracking) begin   // dropping enable aborts the run
			state <= state_w'(st_idle);
			step <= '0;
			pointer_index <= '0;
			blobs_written <= '0;
			clear_addr <= '0;
			fetch_start <= 1'b0;
			if (reset)
				mode_two <= 1'b1;
		end else begin
			fetch_start <= 1'b0;
			case (state)
				state_w'(st_idle): begin
					mode_two <= mode_switches != 2'b01;   // 00, 10 and 11 all mean mode 2
					state <= state_w'(st_clear);
				end
				state_w'(st_clear): begin
					clear_addr <= clear_addr + 1'b1;
					if (clear_addr == buf_addr_w'(mode2_bytes - 1))
						state <= state_w'(st_markers);
				end
				state_w'(st_markers): begin
					step <= step + 1'b1;
					if (step == 2'd3)
						state <= state_w'(st_examine);
				end
				state_w'(st_examine): begin
					if (run_over) begin
						state <= state_w'(st_done);
					end else if (pointer_valid) begin
						fetch_start <= 1'b1;
						state <= state_w'(st_fetch);
					end else begin
						pointer_index <= pointer_index + 1'b1;   // empty slot
					end
				end
				state_w'(st_fetch): begin
					if (fetch_done) begin
						if (color_valid) begin
							state <= state_w'(st_store);
						end else begin
							pointer_index <= pointer_index + 1'b1;
							state <= state_w'(st_examine);
						end
					end
				end
				state_w'(st_store): begin
					step <= step + 1'b1;
					if (step == 2'd3) begin
						blobs_written <= blobs_written + 1'b1;
						pointer_index <= pointer_index + 1'b1;
						state <= state_w'(st_examine);
					end
				end
				default: state <= state_w'(st_done);   // held until enable falls
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(state == state_w'(st_idle) || state == state_w'(st_done)) |-> !write_strobe);

	assert property (@(posedge clk) disable iff (reset) fetch_start |=> !fetch_start);

endmodule

// ==== source/tracking_output_assembly.sv ====
module tracking_output_assembly
	import tracking_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enable_tracking,
	input  logic [1:0] mode_switches,
	input  logic [ptr_idx_w-1:0] number_of_valid_blobs,
	output logic [ptr_idx_w-1:0] pointer_index,
	input  logic [mem_addr_w-1:0] blob_pointer,
	output logic [mem_addr_w-1:0] mem_address,
	input  logic [word_w-1:0] mem_data,
	input  logic [buf_addr_w-1:0] read_addr,
	output logic [byte_w-1:0] read_data,
	output logic [6:0] bytes_to_transmit,
	output logic [color_count-1:0] tracking_display,
	output logic tracking_done
);
	logic fetch_start;
	logic fetch_done;
	logic color_valid;
	logic [color_w-1:0] blob_color;
	logic [word_w-1:0] blob_word;
	logic write_strobe;
	logic [kind_w-1:0] write_kind;
	logic [1:0] field_index;
	logic [buf_addr_w-1:0] clear_addr;
	logic [rank_w-1:0] blob_rank;
	logic mode_two;
	logic clear_display;
	logic [buf_addr_w-1:0] buf_addr;
	logic [byte_w-1:0] buf_byte;

	// display bits drop while the buffer is being cleared
	assign clear_display = write_strobe && (write_kind == kind_w'(kind_clear));

	tracking_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.enable_tracking(enable_tracking),
		.mode_switches(mode_switches),
		.number_of_valid_blobs(number_of_valid_blobs),
		.blob_pointer(blob_pointer),
		.fetch_done(fetch_done),
		.color_valid(color_valid),
		.blob_color(blob_color),
		.pointer_index(pointer_index),
		.fetch_start(fetch_start),
		.write_strobe(write_strobe),
		.write_kind(write_kind),
		.field_index(field_index),
		.clear_addr(clear_addr),
		.blob_rank(blob_rank),
		.mode_two(mode_two),
		.bytes_to_transmit(bytes_to_transmit),
		.tracking_done(tracking_done)
	);

	blob_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.fetch_start(fetch_start),
		.blob_pointer(blob_pointer),
		.mem_data(mem_data),
		.mode_two(mode_two),
		.clear_display(clear_display),
		.mem_address(mem_address),
		.fetch_done(fetch_done),
		.color_valid(color_valid),
		.blob_color(blob_color),
		.blob_word(blob_word),
		.tracking_display(tracking_display)
	);

	slot_mapper u_mapper (
		.write_kind(write_kind),
		.field_index(field_index),
		.clear_addr(clear_addr),
		.blob_rank(blob_rank),
		.blob_color(blob_color),
		.mode_two(mode_two),
		.blob_word(blob_word),
		.buf_addr(buf_addr),
		.buf_byte(buf_byte)
	);

	packet_buffer u_buffer (
		.clk(clk),
		.write_strobe(write_strobe),
		.buf_addr(buf_addr),
		.buf_byte(buf_byte),
		.read_addr(read_addr),
		.read_data(read_data)
	);

endmodule

// ==== verification/blob_memory_model.sv ====
module blob_memory_model
	import tracking_pkg::*;
(
	input  logic clk,
	input  logic [ptr_idx_w-1:0] pointer_index,
	output logic [mem_addr_w-1:0] blob_pointer,
	input  logic [mem_addr_w-1:0] mem_address,
	output logic [word_w-1:0] mem_data
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [mem_addr_w-1:0] pointer_table [0:ptr_slots-1];
	logic [word_w-1:0] words [0:(1 << mem_addr_w) - 1];

	// background pattern carries the full address
	initial begin
		for (int a = 0; a < (1 << mem_addr_w); a++)
			words[a] = {8'hc3, 6'd0, mem_addr_w'(a)};
		for (int s = 0; s < ptr_slots; s++)
			pointer_table[s] = '0;
	end

	// pointer table answers at once, past the last slot it reads as empty
	assign blob_pointer = (pointer_index < ptr_idx_w'(ptr_slots)) ?
		pointer_table[pointer_index] : '0;

	always_ff @(posedge clk) begin
		mem_data <= words[mem_address];   // one cycle read latency
	end

	task automatic clear_pointers();
		for (int s = 0; s < ptr_slots; s++)
			pointer_table[s] = '0;
	endtask

	task automatic load_pointer(input int slot, input logic [mem_addr_w-1:0] ptr);
		pointer_table[slot] = ptr;
	endtask

	task automatic load_word(input logic [mem_addr_w-1:0] addr, input logic [word_w-1:0] data);
		words[addr] = data;
	endtask

endmodule

// ==== verification/tracking_output_assembly_tb.sv ====
module tracking_output_assembly_tb
	import tracking_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int record_words = 128;      // one case per record
	localparam int vector_words = 4 * record_words;
	localparam int slot_field = 4;          // pointer, word one, word two per slot
	localparam int packet_field = 64;
	localparam int done_timeout = 1000;

	logic clk;
	logic reset;
	logic enable_tracking;
	logic [1:0] mode_switches;
	logic [ptr_idx_w-1:0] number_of_valid_blobs;
	logic [ptr_idx_w-1:0] pointer_index;
	logic [mem_addr_w-1:0] blob_pointer;
	logic [mem_addr_w-1:0] mem_address;
	logic [word_w-1:0] mem_data;
	logic [buf_addr_w-1:0] read_addr;
	logic [byte_w-1:0] read_data;
	logic [6:0] bytes_to_transmit;
	logic [color_count-1:0] tracking_display;
	logic tracking_done;
	logic [31:0] vectors [0:vector_words-1];

	tracking_output_assembly uut (
		.clk(clk),
		.reset(reset),
		.enable_tracking(enable_tracking),
		.mode_switches(mode_switches),
		.number_of_valid_blobs(number_of_valid_blobs),
		.pointer_index(pointer_index),
		.blob_pointer(blob_pointer),
		.mem_address(mem_address),
		.mem_data(mem_data),
		.read_addr(read_addr),
		.read_data(read_data),
		.bytes_to_transmit(bytes_to_transmit),
		.tracking_display(tracking_display),
		.tracking_done(tracking_done)
	);

	blob_memory_model u_memory (
		.clk(clk),
		.pointer_index(pointer_index),
		.blob_pointer(blob_pointer),
		.mem_address(mem_address),
		.mem_data(mem_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input int got, input int expected);
		assert (got == expected) else
			stop_run($sformatf("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
				$time, what, got, expected));
	endtask

	// unused slots stay empty, so only listed pointers reach the table
	task automatic load_memory(input int base);
		int entry;
		logic [mem_addr_w-1:0] ptr;
		u_memory.clear_pointers();
		for (int slot = 0; slot < ptr_slots; slot++) begin
			entry = base + slot_field + 3 * slot;
			ptr = vectors[entry][mem_addr_w-1:0];
			if (ptr != '0) begin
				u_memory.load_pointer(slot, ptr);
				u_memory.load_word(ptr, vectors[entry + 1]);
				u_memory.load_word(ptr + 1'b1, vectors[entry + 2]);
			end
		end
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!tracking_done && cycles < done_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!tracking_done)
			stop_run($sformatf("timed out after %0d cycles waiting for tracking_done",
				done_timeout));
	endtask

	// port b has one cycle of latency, so each byte is sampled one negedge later
	task automatic check_packet(input int base);
		for (int addr = 0; addr < mode2_bytes; addr++) begin
			read_addr = buf_addr_w'(addr);
			@(negedge clk);
			check_value($sformatf("packet byte %0d", addr), int'(read_data),
				int'(vectors[base + packet_field + addr][byte_w-1:0]));
		end
	endtask

	task automatic run_case(input int base, input int number);
		load_memory(base);
		@(negedge clk);
		mode_switches = vectors[base][1:0];
		number_of_valid_blobs = vectors[base + 1][ptr_idx_w-1:0];
		enable_tracking = 1'b1;
		wait_for_done();
		check_value("bytes_to_transmit", int'(bytes_to_transmit), int'(vectors[base + 3]));
		check_value("tracking_display", int'(tracking_display), int'(vectors[base + 2]));
		check_packet(base);
		check_value("tracking_done while enabled", int'(tracking_done), 1);   // still held
		enable_tracking = 1'b0;
		read_addr = '0;
		@(negedge clk);
		check_value("tracking_done after enable drop", int'(tracking_done), 0);
		check_value("pointer_index after enable drop", int'(pointer_index), 0);
		$display("case %0d checked, mode switches %b", number, vectors[base][1:0]);
	endtask

	initial begin
		int base;
		int cases_run;
		reset = 1'b1;
		enable_tracking = 1'b0;
		mode_switches = 2'b00;
		number_of_valid_blobs = '0;
		read_addr = '0;
		base = 0;
		cases_run = 0;
		for (int i = 0; i < vector_words; i++)
			vectors[i] = '0;
		$readmemh("verification/tracking_vectors.txt", vectors);

		repeat (5) @(posedge clk);
		@(negedge clk);
		check_value("mem_address in reset", int'(mem_address), 0);
		check_value("tracking_done in reset", int'(tracking_done), 0);
		check_value("tracking_display in reset", int'(tracking_display), 0);
		reset = 1'b0;

		// a zero packet length marks the end of the cases
		while (base < vector_words && vectors[base + 3] != '0) begin
			cases_run++;
			run_case(base, cases_run);
			base += record_words;
		end

		if (cases_run > 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_run("no test cases were found in verification/tracking_vectors.txt");
		end
	end

endmodule

// ==== tracking_output_assembly.f ====
source/tracking_pkg.sv
source/packet_buffer.sv
source/slot_mapper.sv
source/blob_fetch.sv
source/tracking_sequencer.sv
source/tracking_output_assembly.sv
verification/blob_memory_model.sv
verification/tracking_output_assembly_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tracking packet testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tracking_output_assembly_tb \
	-f tracking_output_assembly.f -o tracking_sim

# the log decides the result, so the pipe keeps going on a failing run
./obj_dir/tracking_sim 2>&1 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
	echo "RESULT: PASS"
else
	echo "RESULT: FAIL"
	exit 1
fi

// ==== verification/tracking_vectors.txt ====
// 128 words per case: switches, blob count, display, packet length at +0
// pointer, word one, word two of each slot at +4 + 3*slot, expected packet bytes 0-51 at +64
// case 1: mode 1, rgb at ranks 1 and 2, bad pointer, orange and code 0 skipped, rank 3 left out
@000 1 14 19 1c
@004 30d40 00000001 11121314
@007 30d50 00000004 21222324
@00a 30d60 00000005 31323334
@00d 30d3e 00000001 eeeeeeee
@010 30d70 00000002 41424344
@013 30d80 00000000 51525354
@016 30d90 7f000001 61626364
@019 30da0 00000004 71727374
@01c 30db0 00000005 81828384
@028 30dc0 00000001 91929394
@040 b0 01 11 12 21 22 31 32 61 62 71 72 81 82 13 14 23 24 33 34 63 64 73 74 83 84
@05a 0a 0d 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// case 2: mode 2 by switches 00, six colours at rank 1, two at rank 2, colour code 7 skipped
@080 0 14 3f 34
@084 30d40 5a5a0001 a0a1a2a3
@087 30d50 00000002 b0b1b2b3
@08a 30d60 00000003 c0c1c2c3
@08d 30d70 00000004 d0d1d2d3
@090 30d80 00000005 e0e1e2e3
@093 30d90 00000006 f0f1f2f3
@096 30da0 00000006 15161718
@09c 30db0 00000007 99999999
@09f 30dc0 00000001 25262728
@0c0 b0 02 a0 a1 b0 b1 c0 c1 d0 d1 e0 e1 f0 f1 25 26 00 00 00 00 00 00 00 00 15 16
@0da a2 a3 b2 b3 c2 c3 d2 d3 e2 e3 f2 f3 27 28 00 00 00 00 00 00 00 00 17 18 0a 0d
// case 3: mode 2 by switches 11, run stops after two blobs, stale bytes and display cleared
@100 3 2 14 34
@104 30e00 00000003 3a3b3c3d
@10a 30e10 00000005 4a4b4c4d
@10d 30e20 00000004 5a5b5c5d
@140 b0 02 00 00 00 00 3a 3b 00 00 4a 4b 00 00 00 00 00 00 00 00 00 00 00 00 00 00
@15a 00 00 00 00 3c 3d 00 00 4c 4d 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0a 0d
